//--- files.f
+incdir+include
hdl/w5500_pkg.sv
hdl/spi_frame_engine.sv
hdl/w5500_init_sequencer.sv
hdl/udp_tx_sequencer.sv
hdl/w5500_udp_tx.sv
test/w5500_udp_tx_checker.sv
test/w5500_udp_tx_tb.sv

//--- hdl/spi_frame_engine.sv
`timescale 1ns/10ps
`include "w5500_config.svh"

module spi_frame_engine import w5500_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  frame_req_t req,
    input  logic       req_valid,
    input  logic       miso,
    output logic       mosi,
    output logic       sclk,
    output logic       sel_n,
    output logic       frame_done,
    output logic [7:0] rd_byte
);

    localparam int FRAME_MAX = 24 + `W5500_PAYLOAD_BITS;
    localparam int CNT_W = $clog2(FRAME_MAX);
    localparam int DIV_W = $clog2(`W5500_SPI_DIV + 1);
    localparam logic [CNT_W-1:0] LAST_CMD = CNT_W'(31);
    localparam logic [CNT_W-1:0] LAST_DATA = CNT_W'(FRAME_MAX - 1);
    localparam logic [CNT_W-1:0] RD_FIRST = CNT_W'(24);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`W5500_SPI_DIV - 1);

    logic                 busy;
    logic                 is_cmd;
    logic [DIV_W-1:0]     div_cnt;
    logic [CNT_W-1:0]     bit_cnt;
    logic [FRAME_MAX-1:0] shift_q;
    logic [FRAME_MAX-1:0] load_word;
    logic                 tick;
    logic                 last_bit;
    logic                 start;

    assign start = req_valid && !busy;
    assign tick = busy && (div_cnt == DIV_LAST);
    assign last_bit = bit_cnt == (is_cmd ? LAST_CMD : LAST_DATA);

    // Frame left aligned in the shifter, MSB goes out first
    always_comb begin
        if (req.kind == frame_cmd) begin
            load_word = FRAME_MAX'(req.frame.raw) << (FRAME_MAX - 32);
        end else begin
            load_word = {req.frame.cmd.addr, req.frame.cmd.ctrl, req.payload};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy       <= 1'b0;
            is_cmd     <= 1'b0;
            div_cnt    <= '0;
            bit_cnt    <= '0;
            sclk       <= 1'b0;
            sel_n      <= 1'b1;
            mosi       <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (start) begin
                busy    <= 1'b1;
                is_cmd  <= (req.kind == frame_cmd);
                sel_n   <= 1'b0;
                div_cnt <= '0;
                bit_cnt <= '0;
                mosi    <= load_word[FRAME_MAX-1];
            end else if (busy) begin
                div_cnt <= tick ? '0 : div_cnt + DIV_W'(1);
                if (tick) begin
                    sclk <= ~sclk;
                    // Falling edge ends the bit
                    if (sclk) begin
                        if (last_bit) begin
                            busy       <= 1'b0;
                            sel_n      <= 1'b1;
                            frame_done <= 1'b1;
                            mosi       <= 1'b0;
                        end else begin
                            bit_cnt <= bit_cnt + CNT_W'(1);
                            mosi    <= shift_q[FRAME_MAX-2];
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            shift_q <= load_word;
        end else if (tick && sclk && !last_bit) begin
            shift_q <= shift_q << 1;
        end
        // Read data comes back in the data byte of a command frame
        if (tick && !sclk && is_cmd && bit_cnt >= RD_FIRST) begin
            rd_byte <= {rd_byte[6:0], miso};
        end
    end

endmodule

//--- hdl/udp_tx_sequencer.sv
`timescale 1ns/10ps
`include "w5500_config.svh"

module udp_tx_sequencer import w5500_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       socket_open,
    input  frame_req_t init_req,
    input  logic       init_req_valid,
    input  logic       frame_done,
    input  logic       tx_valid,
    input  payload_t   tx_payload,
    output logic       tx_ready,
    output frame_req_t req,
    output logic       req_valid
);

    typedef enum logic [2:0] {
        st_idle,
        st_data,
        st_ptr_lo,
        st_ptr_hi,
        st_send
    } state_e;

    localparam logic [15:0] PTR_STEP = 16'(`W5500_PAYLOAD_BITS / 8);

    state_e     state;
    logic [15:0] tx_ptr;
    payload_t   payload_q;
    logic       pkt_valid;
    frame_req_t pkt_req;
    logic       accept;

    assign tx_ready = socket_open && (state == st_idle);
    assign accept = tx_valid && tx_ready;

    // Setup traffic owns the engine until the socket is open
    assign req_valid = socket_open ? pkt_valid : init_req_valid;
    assign req = socket_open ? pkt_req : init_req;

    always_comb begin
        pkt_req.kind = frame_cmd;
        pkt_req.payload = payload_q;
        pkt_req.frame.cmd = make_cmd(`W5500_S0_CR, `W5500_CTRL_S0_WR, `W5500_CMD_SEND);
        case (state)
            st_data: begin
                pkt_req.kind = frame_data;
                pkt_req.frame.cmd = make_cmd(tx_ptr, `W5500_CTRL_S0_TXBUF_WR, 8'h00);
            end
            st_ptr_lo: pkt_req.frame.cmd = make_cmd(`W5500_S0_TX_WR_LO, `W5500_CTRL_S0_WR,
                tx_ptr[7:0]);
            st_ptr_hi: pkt_req.frame.cmd = make_cmd(`W5500_S0_TX_WR_HI, `W5500_CTRL_S0_WR,
                tx_ptr[15:8]);
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= st_idle;
            tx_ptr    <= '0;
            pkt_valid <= 1'b0;
        end else begin
            pkt_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (accept) begin
                        state     <= st_data;
                        pkt_valid <= 1'b1;
                    end
                end
                st_data: begin
                    if (frame_done) begin
                        // Pointer frames carry the value after this payload
                        tx_ptr    <= tx_ptr + PTR_STEP;
                        state     <= st_ptr_lo;
                        pkt_valid <= 1'b1;
                    end
                end
                st_ptr_lo: begin
                    if (frame_done) begin
                        state     <= st_ptr_hi;
                        pkt_valid <= 1'b1;
                    end
                end
                st_ptr_hi: begin
                    if (frame_done) begin
                        state     <= st_send;
                        pkt_valid <= 1'b1;
                    end
                end
                st_send: begin
                    if (frame_done) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            payload_q <= tx_payload;
        end
    end

endmodule

//--- hdl/w5500_init_sequencer.sv
`timescale 1ns/10ps
`include "w5500_config.svh"

module w5500_init_sequencer import w5500_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       frame_done,
    input  logic [7:0] rd_byte,
    output frame_req_t init_req,
    output logic       init_req_valid,
    output logic       socket_open
);

    typedef enum logic [1:0] {
        st_issue,
        st_wait,
        st_open
    } state_e;

    localparam logic [4:0] LAST_STEP = 5'd30;

    localparam logic [5:0][7:0] MAC_B = `W5500_MAC;
    localparam logic [3:0][7:0] IP_B = `W5500_IP;
    localparam logic [3:0][7:0] GW_B = `W5500_GW;
    localparam logic [3:0][7:0] MASK_B = `W5500_MASK;
    localparam logic [3:0][7:0] DIP_B = `W5500_DST_IP;
    localparam logic [1:0][7:0] SPORT_B = `W5500_SRC_PORT;
    localparam logic [1:0][7:0] DPORT_B = `W5500_DST_PORT;

    state_e       state;
    logic [4:0]   step;
    logic         polling;
    w5500_frame_u setup_frame;
    w5500_frame_u status_frame;

    // One register byte per frame, multi-byte fields go MSB first
    always_comb begin
        setup_frame.raw = `W5500_PHY_MODE_FRAME;
        case (step) inside
            [5'd1:5'd6]: setup_frame.cmd = make_cmd(`W5500_SHAR + 16'(step - 5'd1),
                `W5500_CTRL_COMMON_WR, MAC_B[3'(5'd6 - step)]);
            [5'd7:5'd10]: setup_frame.cmd = make_cmd(`W5500_SIPR + 16'(step - 5'd7),
                `W5500_CTRL_COMMON_WR, IP_B[2'(5'd10 - step)]);
            [5'd11:5'd14]: setup_frame.cmd = make_cmd(`W5500_GAR + 16'(step - 5'd11),
                `W5500_CTRL_COMMON_WR, GW_B[2'(5'd14 - step)]);
            [5'd15:5'd18]: setup_frame.cmd = make_cmd(`W5500_SUBR + 16'(step - 5'd15),
                `W5500_CTRL_COMMON_WR, MASK_B[2'(5'd18 - step)]);
            5'd19: setup_frame.cmd = make_cmd(`W5500_S0_MR, `W5500_CTRL_S0_WR,
                `W5500_MODE_UDP);
            5'd20: setup_frame.cmd = make_cmd(`W5500_S0_RXBUF_SIZE, `W5500_CTRL_S0_WR,
                `W5500_BUF_KB);
            5'd21: setup_frame.cmd = make_cmd(`W5500_S0_TXBUF_SIZE, `W5500_CTRL_S0_WR,
                `W5500_BUF_KB);
            [5'd22:5'd23]: setup_frame.cmd = make_cmd(`W5500_S0_PORT + 16'(step - 5'd22),
                `W5500_CTRL_S0_WR, SPORT_B[1'(5'd23 - step)]);
            5'd24: setup_frame.cmd = make_cmd(`W5500_S0_CR, `W5500_CTRL_S0_WR,
                `W5500_CMD_OPEN);
            [5'd25:5'd28]: setup_frame.cmd = make_cmd(`W5500_S0_DIPR + 16'(step - 5'd25),
                `W5500_CTRL_S0_WR, DIP_B[2'(5'd28 - step)]);
            [5'd29:5'd30]: setup_frame.cmd = make_cmd(`W5500_S0_DPORT + 16'(step - 5'd29),
                `W5500_CTRL_S0_WR, DPORT_B[1'(5'd30 - step)]);
            default: setup_frame.raw = `W5500_PHY_MODE_FRAME;
        endcase
    end

    assign status_frame.cmd = make_cmd(`W5500_S0_SR, `W5500_CTRL_S0_RD, 8'h00);

    assign init_req.kind = frame_cmd;
    assign init_req.frame = polling ? status_frame : setup_frame;
    assign init_req.payload = '0;

    assign socket_open = (state == st_open);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state          <= st_issue;
            step           <= '0;
            polling        <= 1'b0;
            init_req_valid <= 1'b0;
        end else begin
            init_req_valid <= 1'b0;
            case (state)
                st_issue: begin
                    init_req_valid <= 1'b1;
                    state          <= st_wait;
                end
                st_wait: begin
                    if (frame_done) begin
                        if (!polling) begin
                            state <= st_issue;
                            if (step == LAST_STEP) begin
                                polling <= 1'b1;
                            end else begin
                                step <= step + 5'd1;
                            end
                        end else if (rd_byte == `W5500_SOCK_UDP) begin
                            state <= st_open;
                        end else begin
                            state <= st_issue;
                        end
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

//--- hdl/w5500_pkg.sv
`include "w5500_config.svh"

package w5500_pkg;

    // One SPI command frame as the W5500 sees it
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  ctrl;
        logic [7:0]  data;
    } w5500_cmd_t;

    // Sequencers fill fields, the engine shifts the raw word
    typedef union packed {
        w5500_cmd_t  cmd;
        logic [31:0] raw;
    } w5500_frame_u;

    typedef logic [`W5500_PAYLOAD_BITS-1:0] payload_t;

    typedef enum logic {
        frame_cmd,
        frame_data
    } frame_kind_e;

    // For a data frame, frame.cmd.addr is the TX pointer and frame.cmd.ctrl the buffer block
    typedef struct packed {
        frame_kind_e  kind;
        w5500_frame_u frame;
        payload_t     payload;
    } frame_req_t;

    function automatic w5500_cmd_t make_cmd(
        input logic [15:0] addr,
        input logic [7:0]  ctrl,
        input logic [7:0]  data
    );
        w5500_cmd_t c;
        c.addr = addr;
        c.ctrl = ctrl;
        c.data = data;
        return c;
    endfunction

endpackage

//--- hdl/w5500_udp_tx.sv
`timescale 1ns/10ps

module w5500_udp_tx import w5500_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     miso,
    input  logic     tx_valid,
    input  payload_t tx_payload,
    output logic     mosi,
    output logic     sclk,
    output logic     sel_n,
    output logic     tx_ready
);

    frame_req_t init_req;
    logic       init_req_valid;
    logic       socket_open;
    frame_req_t req;
    logic       req_valid;
    logic       frame_done;
    logic [7:0] rd_byte;

    w5500_init_sequencer init_seq_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .frame_done     (frame_done),
        .rd_byte        (rd_byte),
        .init_req       (init_req),
        .init_req_valid (init_req_valid),
        .socket_open    (socket_open)
    );

    udp_tx_sequencer tx_seq_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .socket_open    (socket_open),
        .init_req       (init_req),
        .init_req_valid (init_req_valid),
        .frame_done     (frame_done),
        .tx_valid       (tx_valid),
        .tx_payload     (tx_payload),
        .tx_ready       (tx_ready),
        .req            (req),
        .req_valid      (req_valid)
    );

    spi_frame_engine spi_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .req        (req),
        .req_valid  (req_valid),
        .miso       (miso),
        .mosi       (mosi),
        .sclk       (sclk),
        .sel_n      (sel_n),
        .frame_done (frame_done),
        .rd_byte    (rd_byte)
    );

endmodule

//--- include/w5500_config.svh
`ifndef W5500_CONFIG_SVH
`define W5500_CONFIG_SVH

// Payload width, whole bytes only
`define W5500_PAYLOAD_BITS 64
// clk cycles per sclk half period
`define W5500_SPI_DIV 2

// Local network identity
`define W5500_MAC 48'hAAAF_FACC_E31C
`define W5500_IP 32'hC0A8_0AC2
`define W5500_MASK 32'hFFFF_FF00
`define W5500_GW 32'hC0A8_0A01
`define W5500_SRC_PORT 16'd2390
`define W5500_DST_IP 32'hC0A8_0A14
`define W5500_DST_PORT 16'd5000

// 100 Mbit full duplex, written as one complete frame
`define W5500_PHY_MODE_FRAME 32'h002E_04D8

// Control bytes: block select, read/write, variable length
`define W5500_CTRL_COMMON_WR 8'h04
`define W5500_CTRL_S0_WR 8'h0C
`define W5500_CTRL_S0_RD 8'h08
`define W5500_CTRL_S0_TXBUF_WR 8'h14

// Common register block
`define W5500_GAR 16'h0001
`define W5500_SUBR 16'h0005
`define W5500_SHAR 16'h0009
`define W5500_SIPR 16'h000F

// Socket 0 register block
`define W5500_S0_MR 16'h0000
`define W5500_S0_CR 16'h0001
`define W5500_S0_SR 16'h0003
`define W5500_S0_PORT 16'h0004
`define W5500_S0_DIPR 16'h000C
`define W5500_S0_DPORT 16'h0010
`define W5500_S0_RXBUF_SIZE 16'h001E
`define W5500_S0_TXBUF_SIZE 16'h001F
`define W5500_S0_TX_WR_HI 16'h0024
`define W5500_S0_TX_WR_LO 16'h0025

// Register values
`define W5500_MODE_UDP 8'h02
`define W5500_BUF_KB 8'd16
`define W5500_CMD_OPEN 8'h01
`define W5500_CMD_SEND 8'h20
`define W5500_SOCK_UDP 8'h22

`endif

//--- run.sh
#!/bin/sh
# Build the W5500 UDP transmit testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module w5500_udp_tx_tb -o sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx '=== PASS ==='; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- test/w5500_udp_tx_checker.sv
`timescale 1ns/10ps

module w5500_udp_tx_checker (
    input logic clk,
    input logic arst_n,
    input logic sel_n,
    input logic sclk,
    input logic tx_valid,
    input logic tx_ready
);

    int fail_count = 0;

    // SPI mode 0 keeps the clock low between frames
    sclk_idle_low: assert property (@(posedge clk) disable iff (!arst_n) sel_n |-> !sclk)
        else begin
            fail_count++;
            $error("sclk is high while sel_n is high");
        end

    // No back-pressure, a strobe is only legal when ready
    valid_needs_ready: assert property (@(posedge clk) disable iff (!arst_n)
        tx_valid |-> tx_ready)
        else begin
            fail_count++;
            $error("tx_valid asserted while tx_ready is low");
        end

    ready_low_in_frame: assert property (@(posedge clk) disable iff (!arst_n)
        !sel_n |-> !tx_ready)
        else begin
            fail_count++;
            $error("tx_ready is high while a frame is on the bus");
        end

endmodule

//--- test/w5500_udp_tx_tb.sv
`timescale 1ns/10ps
`include "w5500_config.svh"

module w5500_udp_tx_tb import w5500_pkg::*; ();

    localparam int FRAME_MAX = 24 + `W5500_PAYLOAD_BITS;
    localparam int N_ROWS = 4;
    localparam int SETUP_FRAMES = 31;
    localparam int POLL_FRAMES = 3;
    localparam int CMD_FRAMES = SETUP_FRAMES + POLL_FRAMES + 3 * N_ROWS;
    localparam int ALL_FRAMES = CMD_FRAMES + N_ROWS;
    // Every bit costs two half periods, plus a gap per frame and some slack
    localparam int TIMEOUT_CYCLES = (CMD_FRAMES * 32 + N_ROWS * FRAME_MAX) * 2 * `W5500_SPI_DIV
        + ALL_FRAMES * 10 + 500;
    localparam logic [15:0] PTR_STEP = 16'(`W5500_PAYLOAD_BITS / 8);

    typedef struct packed {
        payload_t     payload;
        logic [15:0]  ptr;
        w5500_frame_u lo;
        w5500_frame_u hi;
        w5500_frame_u send;
    } row_t;

    logic     clk;
    logic     arst_n;
    logic     miso = 1'b0;
    logic     tx_valid;
    payload_t tx_payload;
    logic     mosi;
    logic     sclk;
    logic     sel_n;
    logic     tx_ready;

    logic [FRAME_MAX-1:0] frame_bits[$];
    int                   frame_len[$];
    logic [FRAME_MAX-1:0] cap_word;
    logic [23:0]          cap_hdr;
    int                   cap_cnt = 0;
    int                   status_reads = 0;
    int                   cycle_cnt = 0;
    logic [16:0]          lfsr_q = 17'd77161;
    w5500_frame_u         setup_exp[SETUP_FRAMES];
    int                   setup_n = 0;
    row_t                 rows[N_ROWS];

    w5500_udp_tx dut_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .miso       (miso),
        .tx_valid   (tx_valid),
        .tx_payload (tx_payload),
        .mosi       (mosi),
        .sclk       (sclk),
        .sel_n      (sel_n),
        .tx_ready   (tx_ready)
    );

    bind w5500_udp_tx w5500_udp_tx_checker checker_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .sel_n    (sel_n),
        .sclk     (sclk),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // W5500 side: shift in on rising sclk, close the frame when sel_n rises
    always @(posedge sclk or posedge sel_n) begin
        if (sel_n) begin
            if (cap_cnt != 0) begin
                frame_bits.push_back(cap_word);
                frame_len.push_back(cap_cnt);
                if (cap_cnt == 32 && cap_hdr == {`W5500_S0_SR, `W5500_CTRL_S0_RD}) begin
                    status_reads++;
                end
            end
            cap_cnt = 0;
            cap_hdr = '0;
            cap_word = '0;
        end else begin
            cap_word = {cap_word[FRAME_MAX-2:0], mosi};
            cap_cnt++;
            if (cap_cnt == 24) begin
                cap_hdr = cap_word[23:0];
            end
        end
    end

    // Socket opens on the third status read
    always @(posedge clk) begin
        logic [7:0] reply;
        reply = (status_reads < 2) ? 8'h00 : `W5500_SOCK_UDP;
        if (!sel_n && cap_cnt >= 24 && cap_cnt < 32
            && cap_hdr == {`W5500_S0_SR, `W5500_CTRL_S0_RD}) begin
            miso <= reply[3'(31 - cap_cnt)];
        end else begin
            miso <= 1'b0;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            stop_with_failure($sformatf("timeout after %0d cycles with %0d of %0d frames seen",
                cycle_cnt, frame_len.size(), ALL_FRAMES));
        end
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_cmd(input string name, input w5500_frame_u got, input w5500_frame_u exp);
        if (got.raw !== exp.raw) begin
            stop_with_failure($sformatf("error: %s got %h expected %h", name, got.raw, exp.raw));
        end
    endtask

    task automatic check_data(input string name, input logic [15:0] got_ptr,
        input logic [7:0] got_ctrl, input payload_t got_pay, input logic [15:0] exp_ptr,
        input payload_t exp_pay);
        if (got_ptr !== exp_ptr) begin
            stop_with_failure($sformatf("error: %s pointer got %h expected %h",
                name, got_ptr, exp_ptr));
        end
        if (got_ctrl !== `W5500_CTRL_S0_TXBUF_WR) begin
            stop_with_failure($sformatf("error: %s ctrl got %h expected %h",
                name, got_ctrl, `W5500_CTRL_S0_TXBUF_WR));
        end
        if (got_pay !== exp_pay) begin
            stop_with_failure($sformatf("error: %s payload got %h expected %h",
                name, got_pay, exp_pay));
        end
    endtask

    task automatic expect_cmd_frame(input int k, input w5500_frame_u exp);
        w5500_frame_u got;
        if (frame_len[k] != 32) begin
            stop_with_failure($sformatf("frame %0d has %0d bits, a command frame has 32",
                k, frame_len[k]));
        end
        got.raw = frame_bits[k][31:0];
        check_cmd($sformatf("frame %0d", k), got, exp);
    endtask

    task automatic expect_data_frame(input int k, input logic [15:0] ptr, input payload_t pay);
        if (frame_len[k] != FRAME_MAX) begin
            stop_with_failure($sformatf("frame %0d has %0d bits, a data frame has %0d",
                k, frame_len[k], FRAME_MAX));
        end
        check_data($sformatf("frame %0d", k), frame_bits[k][FRAME_MAX-1 -: 16],
            frame_bits[k][FRAME_MAX-17 -: 8], frame_bits[k][`W5500_PAYLOAD_BITS-1:0], ptr, pay);
    endtask

    // tx_ready must stay low until the wanted number of frames has closed
    task automatic wait_frames(input int n);
        while (frame_len.size() < n) begin
            @(negedge clk);
            check_level("tx_ready", tx_ready, 1'b0);
        end
    endtask

    task automatic check_idle_levels();
        check_level("sel_n", sel_n, 1'b1);
        check_level("sclk", sclk, 1'b0);
        check_level("mosi", mosi, 1'b0);
        check_level("tx_ready", tx_ready, 1'b0);
    endtask

    function automatic w5500_frame_u pack_frame(input logic [15:0] addr, input logic [7:0] ctrl,
        input logic [7:0] data);
        w5500_frame_u f;
        f.raw = {addr, ctrl, data};
        return f;
    endfunction

    // Multi-byte registers are written MSB first at rising addresses
    task automatic add_bytes(input logic [15:0] base, input logic [7:0] ctrl,
        input logic [47:0] value, input int count);
        for (int i = 0; i < count; i++) begin
            setup_exp[setup_n] = pack_frame(base + 16'(i), ctrl,
                8'(value >> (8 * (count - 1 - i))));
            setup_n++;
        end
    endtask

    task automatic build_setup_list();
        setup_exp[0].raw = `W5500_PHY_MODE_FRAME;
        setup_n = 1;
        add_bytes(`W5500_SHAR, `W5500_CTRL_COMMON_WR, `W5500_MAC, 6);
        add_bytes(`W5500_SIPR, `W5500_CTRL_COMMON_WR, 48'(`W5500_IP), 4);
        add_bytes(`W5500_GAR, `W5500_CTRL_COMMON_WR, 48'(`W5500_GW), 4);
        add_bytes(`W5500_SUBR, `W5500_CTRL_COMMON_WR, 48'(`W5500_MASK), 4);
        add_bytes(`W5500_S0_MR, `W5500_CTRL_S0_WR, 48'(`W5500_MODE_UDP), 1);
        add_bytes(`W5500_S0_RXBUF_SIZE, `W5500_CTRL_S0_WR, 48'(`W5500_BUF_KB), 1);
        add_bytes(`W5500_S0_TXBUF_SIZE, `W5500_CTRL_S0_WR, 48'(`W5500_BUF_KB), 1);
        add_bytes(`W5500_S0_PORT, `W5500_CTRL_S0_WR, 48'(`W5500_SRC_PORT), 2);
        add_bytes(`W5500_S0_CR, `W5500_CTRL_S0_WR, 48'(`W5500_CMD_OPEN), 1);
        add_bytes(`W5500_S0_DIPR, `W5500_CTRL_S0_WR, 48'(`W5500_DST_IP), 4);
        add_bytes(`W5500_S0_DPORT, `W5500_CTRL_S0_WR, 48'(`W5500_DST_PORT), 2);
    endtask

    // Fibonacci LFSR, x^17 + x^14 + 1
    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    function automatic payload_t random_payload();
        payload_t p;
        p = '0;
        for (int b = 0; b < `W5500_PAYLOAD_BITS; b++) begin
            p = {p[`W5500_PAYLOAD_BITS-2:0], lfsr_q[16]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return p;
    endfunction

    task automatic build_rows();
        logic [15:0] next_ptr;
        rows[0].payload = '1;
        rows[1].payload = {(`W5500_PAYLOAD_BITS / 8){8'h01}};
        rows[2].payload = random_payload();
        rows[3].payload = random_payload();
        for (int r = 0; r < N_ROWS; r++) begin
            rows[r].ptr = PTR_STEP * 16'(r);
            next_ptr = rows[r].ptr + PTR_STEP;
            rows[r].lo = pack_frame(`W5500_S0_TX_WR_LO, `W5500_CTRL_S0_WR, next_ptr[7:0]);
            rows[r].hi = pack_frame(`W5500_S0_TX_WR_HI, `W5500_CTRL_S0_WR, next_ptr[15:8]);
            rows[r].send = pack_frame(`W5500_S0_CR, `W5500_CTRL_S0_WR, 8'h20);
        end
    endtask

    initial begin
        int base;
        arst_n = 1'b0;
        tx_valid = 1'b0;
        tx_payload = '0;
        build_setup_list();
        build_rows();

        repeat (5) @(negedge clk);
        check_idle_levels();
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_idle_levels();

        wait_frames(SETUP_FRAMES + POLL_FRAMES);
        @(negedge clk);
        check_level("tx_ready", tx_ready, 1'b1);
        for (int k = 0; k < SETUP_FRAMES; k++) begin
            expect_cmd_frame(k, setup_exp[k]);
        end
        for (int k = SETUP_FRAMES; k < SETUP_FRAMES + POLL_FRAMES; k++) begin
            expect_cmd_frame(k, pack_frame(`W5500_S0_SR, `W5500_CTRL_S0_RD, 8'h00));
        end

        for (int r = 0; r < N_ROWS; r++) begin
            base = SETUP_FRAMES + POLL_FRAMES + 4 * r;
            @(posedge clk);
            tx_valid   <= 1'b1;
            tx_payload <= rows[r].payload;
            @(posedge clk);
            tx_valid <= 1'b0;
            wait_frames(base + 4);
            @(negedge clk);
            check_level("tx_ready", tx_ready, 1'b1);
            expect_data_frame(base, rows[r].ptr, rows[r].payload);
            expect_cmd_frame(base + 1, rows[r].lo);
            expect_cmd_frame(base + 2, rows[r].hi);
            expect_cmd_frame(base + 3, rows[r].send);
        end

        @(negedge clk);
        if (dut_i.checker_i.fail_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("%0d protocol assertion failures", dut_i.checker_i.fail_count);
            $display("=== FAIL ===");
            $fatal(1, "protocol assertions failed");
        end
    end

endmodule
